/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mips_pcpu
FILELIST = build.f
OBJ      = obj_dir

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ)

/* build.f */
+incdir+.
mips_pkg.sv
mips_hazard_if.sv
mips_regfile.sv
mips_alu.sv
mips_fetch_decode.sv
mips_execute.sv
mips_writeback.sv
mips_hazard_unit.sv
mips_pcpu.sv
mips_pcpu_props.sv
tb_mips_pcpu.sv

/* mips_alu.sv */
// ******************************
// no overflow detect, slt is signed
// ******************************
`timescale 1ns/1ns

module mips_alu
    import mips_pkg::*;
(
    input  word_t   src_a,
    input  word_t   src_b,
    input  alu_op_t op,
    output word_t   result
);
    logic lt;

    assign lt = $signed(src_a) < $signed(src_b);

    always_comb begin
        case (op)
            ALU_SUB: result = src_a - src_b;
            ALU_AND: result = src_a & src_b;
            ALU_OR:  result = src_a | src_b;
            ALU_SLT: result = word_t'(lt);
            default: result = src_a + src_b;    // add, also address calc
        endcase
    end

endmodule

/* mips_consts.svh */
// ******************************
// opcodes and funct codes of the kept MIPS subset only
// pc counts words and resets to zero
// ******************************
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// opcodes
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_LW    6'h23
`define MIPS_OP_SW    6'h2b
`define MIPS_OP_BEQ   6'h04

// funct codes for R-type
`define MIPS_FN_ADDU  6'h21
`define MIPS_FN_SUBU  6'h23
`define MIPS_FN_AND   6'h24
`define MIPS_FN_OR    6'h25
`define MIPS_FN_SLT   6'h2a

// low bit of each instruction field
`define MIPS_OP_LSB   26
`define MIPS_RS_LSB   21
`define MIPS_RT_LSB   16
`define MIPS_RD_LSB   11
`define MIPS_FN_LSB   0
`define MIPS_IMM_LSB  0

`define MIPS_RESET_PC 32'h0000_0000
`define MIPS_NOP      32'h0000_0000   // squashed stage, decodes to no write

`endif

/* mips_execute.sv */
// ******************************
// a flush turns the decode/execute register into a bubble
// ******************************
`timescale 1ns/1ns

module mips_execute
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    mips_hazard_if.execute hz,
    input  word_t    rd_rs,
    input  word_t    rd_rt,
    input  word_t    sign_imm,
    input  reg_num_t rs,
    input  reg_num_t rt,
    input  reg_num_t rd,
    input  logic     reg_write_d,
    input  logic     reg_dst_d,
    input  logic     alu_src_d,
    input  logic     mem_write_d,
    input  logic     mem_to_reg_d,
    input  alu_op_t  alu_op_d,
    input  word_t    write_data_w,
    output word_t    alu_result_m,
    output word_t    dm_wdata,
    output logic     dm_we,
    output reg_num_t write_reg_m,
    output logic     reg_write_m,
    output logic     mem_to_reg_m
);
    word_t    rd_rs_e, rd_rt_e, sign_imm_e, src_a, write_data_e, alu_result_e;
    reg_num_t rd_e;
    logic     reg_dst_e, alu_src_e, mem_write_e;
    alu_op_t  alu_op_e;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf, word_t from_m,
                                      word_t from_w);
        case (sel)
            FWD_MEM: return from_m;
            FWD_WB:  return from_w;
            default: return rf;
        endcase
    endfunction

    // ******************************
    // decode/execute register
    // ******************************
    always_ff @(posedge clk) begin
        if (rst || hz.flush_e) begin
            hz.reg_write_e  <= 1'b0;
            hz.mem_to_reg_e <= 1'b0;
            mem_write_e     <= 1'b0;
            reg_dst_e       <= 1'b0;
            alu_src_e       <= 1'b0;
            alu_op_e        <= ALU_ADD;
            hz.rs_e         <= '0;
            hz.rt_e         <= '0;
            rd_e            <= '0;
        end else begin
            hz.reg_write_e  <= reg_write_d;
            hz.mem_to_reg_e <= mem_to_reg_d;
            mem_write_e     <= mem_write_d;
            reg_dst_e       <= reg_dst_d;
            alu_src_e       <= alu_src_d;
            alu_op_e        <= alu_op_d;
            hz.rs_e         <= rs;
            hz.rt_e         <= rt;
            rd_e            <= rd;
        end
    end

    always_ff @(posedge clk) begin
        rd_rs_e    <= rd_rs;
        rd_rt_e    <= rd_rt;
        sign_imm_e <= sign_imm;
    end

    // memory stage wins over writeback
    assign src_a        = fwd_mux(hz.fwd_a_e, rd_rs_e, alu_result_m, write_data_w);
    assign write_data_e = fwd_mux(hz.fwd_b_e, rd_rt_e, alu_result_m, write_data_w);
    assign hz.write_reg_e = reg_dst_e ? rd_e : hz.rt_e;

    mips_alu alu_inst (
        .src_a  (src_a),
        .src_b  (alu_src_e ? sign_imm_e : write_data_e),
        .op     (alu_op_e),
        .result (alu_result_e)
    );

    // ******************************
    // execute/memory register
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
            dm_we        <= 1'b0;
        end else begin
            reg_write_m  <= hz.reg_write_e;
            mem_to_reg_m <= hz.mem_to_reg_e;
            dm_we        <= mem_write_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m <= alu_result_e;
        dm_wdata     <= write_data_e;    // store data after forwarding
        write_reg_m  <= hz.write_reg_e;
    end

    assign hz.write_reg_m  = write_reg_m;
    assign hz.reg_write_m  = reg_write_m;
    assign hz.mem_to_reg_m = mem_to_reg_m;

endmodule

/* mips_fetch_decode.sv */
// ******************************
// word-addressed pc, branch resolved in decode, no delay slot
// ******************************
`timescale 1ns/1ns
`include "mips_consts.svh"

module mips_fetch_decode
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    mips_hazard_if.decode hz,
    output word_t    im_addr,
    input  word_t    im_data,
    input  reg_num_t reg_addr,
    output word_t    reg_data,
    input  word_t    alu_result_m,
    input  reg_num_t write_reg_w,
    input  word_t    write_data_w,
    input  logic     reg_write_w,
    output word_t    rd_rs,
    output word_t    rd_rt,
    output word_t    sign_imm,
    output reg_num_t rs,
    output reg_num_t rt,
    output reg_num_t rd,
    output logic     reg_write_d,
    output logic     reg_dst_d,
    output logic     alu_src_d,
    output logic     mem_write_d,
    output logic     mem_to_reg_d,
    output alu_op_t  alu_op_d
);
    word_t pc, pc_next_d, instr_d, rd_debug, src_a_d, src_b_d;
    logic  pc_src;
    imm_t  imm;
    logic [5:0] op, fn;

    // ******************************
    // fetch
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= `MIPS_RESET_PC;
            instr_d <= `MIPS_NOP;
        end else if (!hz.stall) begin
            pc      <= pc_src ? pc_next_d + sign_imm : pc + 1;
            instr_d <= pc_src ? `MIPS_NOP : im_data;    // squash behind taken beq
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.stall) begin
            pc_next_d <= pc + 1;
        end
    end

    assign im_addr = pc;

    // ******************************
    // decode
    // ******************************
    assign op       = instr_d[`MIPS_OP_LSB +: 6];
    assign fn       = instr_d[`MIPS_FN_LSB +: 6];
    assign rs       = instr_d[`MIPS_RS_LSB +: $bits(reg_num_t)];
    assign rt       = instr_d[`MIPS_RT_LSB +: $bits(reg_num_t)];
    assign rd       = instr_d[`MIPS_RD_LSB +: $bits(reg_num_t)];
    assign imm      = instr_d[`MIPS_IMM_LSB +: $bits(imm_t)];
    assign sign_imm = {{16{imm[15]}}, imm};

    assign hz.rs_d     = rs;
    assign hz.rt_d     = rt;
    assign hz.branch_d = (op == `MIPS_OP_BEQ);

    always_comb begin
        reg_write_d  = 1'b0;
        reg_dst_d    = 1'b0;
        alu_src_d    = 1'b0;
        mem_write_d  = 1'b0;
        mem_to_reg_d = 1'b0;
        alu_op_d     = ALU_ADD;
        case (op)
            `MIPS_OP_RTYPE: begin
                reg_dst_d   = 1'b1;
                reg_write_d = 1'b1;
                case (fn)
                    `MIPS_FN_ADDU: alu_op_d = ALU_ADD;
                    `MIPS_FN_SUBU: alu_op_d = ALU_SUB;
                    `MIPS_FN_AND:  alu_op_d = ALU_AND;
                    `MIPS_FN_OR:   alu_op_d = ALU_OR;
                    `MIPS_FN_SLT:  alu_op_d = ALU_SLT;
                    default:       reg_write_d = 1'b0;    // nop and unknown funct
                endcase
            end
            `MIPS_OP_ADDIU: begin
                reg_write_d = 1'b1;
                alu_src_d   = 1'b1;
            end
            `MIPS_OP_LW: begin
                reg_write_d  = 1'b1;
                alu_src_d    = 1'b1;
                mem_to_reg_d = 1'b1;
            end
            `MIPS_OP_SW: begin
                alu_src_d   = 1'b1;
                mem_write_d = 1'b1;
            end
            default: ;    // beq writes nothing
        endcase
    end

    mips_regfile regfile_inst (
        .clk      (clk),
        .a_debug  (reg_addr),
        .a_rs     (rs),
        .a_rt     (rt),
        .rd_debug (rd_debug),
        .rd_rs    (rd_rs),
        .rd_rt    (rd_rt),
        .wa       (write_reg_w),
        .wd       (write_data_w),
        .we       (reg_write_w)
    );

    assign reg_data = (reg_addr == '0) ? pc : rd_debug;    // $0 slot shows the pc

    // early branch compare, forwarded from memory stage only
    assign src_a_d = hz.fwd_a_d ? alu_result_m : rd_rs;
    assign src_b_d = hz.fwd_b_d ? alu_result_m : rd_rt;
    assign pc_src  = hz.branch_d && (src_a_d == src_b_d);

endmodule

/* mips_hazard_if.sv */
// ******************************
// register numbers and controls seen by the hazard unit
// ******************************
`timescale 1ns/1ns

interface mips_hazard_if
    import mips_pkg::*;
();
    reg_num_t rs_d, rt_d;
    logic     branch_d;
    logic     stall;
    logic     fwd_a_d, fwd_b_d;    // branch compare takes alu_result_m

    reg_num_t rs_e, rt_e, write_reg_e;
    logic     reg_write_e, mem_to_reg_e;
    logic     flush_e;
    fwd_sel_t fwd_a_e, fwd_b_e;

    reg_num_t write_reg_m, write_reg_w;
    logic     reg_write_m, mem_to_reg_m, reg_write_w;

    modport decode (output rs_d, rt_d, branch_d, input stall, fwd_a_d, fwd_b_d);
    modport execute (output rs_e, rt_e, write_reg_e, reg_write_e, mem_to_reg_e,
                     write_reg_m, reg_write_m, mem_to_reg_m,
                     input flush_e, fwd_a_e, fwd_b_e);
    modport writeback (output write_reg_w, reg_write_w);
    modport hazard (input rs_d, rt_d, branch_d, rs_e, rt_e, write_reg_e, reg_write_e,
                    mem_to_reg_e, write_reg_m, reg_write_m, mem_to_reg_m,
                    write_reg_w, reg_write_w,
                    output stall, flush_e, fwd_a_d, fwd_b_d, fwd_a_e, fwd_b_e);

endinterface

/* mips_hazard_unit.sv */
// ******************************
// forwarding selects and a single stall for fetch and decode
// ******************************
`timescale 1ns/1ns

module mips_hazard_unit
    import mips_pkg::*;
(
    mips_hazard_if.hazard hz
);
    logic load_stall, branch_stall;

    function automatic fwd_sel_t fwd_e(reg_num_t src, reg_num_t wr_m, logic we_m,
                                       reg_num_t wr_w, logic we_w);
        if (src == '0) begin
            return FWD_NONE;
        end else if (we_m && src == wr_m) begin
            return FWD_MEM;
        end else if (we_w && src == wr_w) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign hz.fwd_a_e = fwd_e(hz.rs_e, hz.write_reg_m, hz.reg_write_m,
                              hz.write_reg_w, hz.reg_write_w);
    assign hz.fwd_b_e = fwd_e(hz.rt_e, hz.write_reg_m, hz.reg_write_m,
                              hz.write_reg_w, hz.reg_write_w);

    // branch operands, memory stage only
    assign hz.fwd_a_d = hz.rs_d != '0 && hz.rs_d == hz.write_reg_m && hz.reg_write_m;
    assign hz.fwd_b_d = hz.rt_d != '0 && hz.rt_d == hz.write_reg_m && hz.reg_write_m;

    // load result not ready for decode
    assign load_stall = hz.mem_to_reg_e &&
                        (hz.write_reg_e == hz.rs_d || hz.write_reg_e == hz.rt_d);

    // beq operand still in flight
    assign branch_stall = hz.branch_d && (
        (hz.reg_write_e && (hz.write_reg_e == hz.rs_d || hz.write_reg_e == hz.rt_d)) ||
        (hz.mem_to_reg_m && (hz.write_reg_m == hz.rs_d || hz.write_reg_m == hz.rt_d)));

    assign hz.stall   = load_stall || branch_stall;
    assign hz.flush_e = hz.stall;    // bubble into execute

endmodule

/* mips_pcpu.sv */
// ******************************
// both memories answer in the same cycle, word addressed
// ******************************
`timescale 1ns/1ns

module mips_pcpu
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_num_t reg_addr,     // debug read, 0 gives the pc
    output word_t    reg_data,
    output word_t    im_addr,
    input  word_t    im_data,
    output word_t    dm_addr,
    output logic     dm_we,
    output word_t    dm_wdata,
    input  word_t    dm_rdata
);
    word_t    rd_rs, rd_rt, sign_imm, alu_result_m, write_data_w;
    reg_num_t rs, rt, rd, write_reg_m, write_reg_w;
    logic     reg_write_d, reg_dst_d, alu_src_d, mem_write_d, mem_to_reg_d;
    logic     reg_write_m, mem_to_reg_m, reg_write_w;
    alu_op_t  alu_op_d;

    mips_hazard_if hz ();

    mips_fetch_decode fetch_decode_inst (
        .clk          (clk),
        .rst          (rst),
        .hz           (hz.decode),
        .im_addr      (im_addr),
        .im_data      (im_data),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .alu_result_m (alu_result_m),
        .write_reg_w  (write_reg_w),
        .write_data_w (write_data_w),
        .reg_write_w  (reg_write_w),
        .rd_rs        (rd_rs),
        .rd_rt        (rd_rt),
        .sign_imm     (sign_imm),
        .rs           (rs),
        .rt           (rt),
        .rd           (rd),
        .reg_write_d  (reg_write_d),
        .reg_dst_d    (reg_dst_d),
        .alu_src_d    (alu_src_d),
        .mem_write_d  (mem_write_d),
        .mem_to_reg_d (mem_to_reg_d),
        .alu_op_d     (alu_op_d)
    );

    mips_execute execute_inst (
        .clk          (clk),
        .rst          (rst),
        .hz           (hz.execute),
        .rd_rs        (rd_rs),
        .rd_rt        (rd_rt),
        .sign_imm     (sign_imm),
        .rs           (rs),
        .rt           (rt),
        .rd           (rd),
        .reg_write_d  (reg_write_d),
        .reg_dst_d    (reg_dst_d),
        .alu_src_d    (alu_src_d),
        .mem_write_d  (mem_write_d),
        .mem_to_reg_d (mem_to_reg_d),
        .alu_op_d     (alu_op_d),
        .write_data_w (write_data_w),
        .alu_result_m (alu_result_m),
        .dm_wdata     (dm_wdata),
        .dm_we        (dm_we),
        .write_reg_m  (write_reg_m),
        .reg_write_m  (reg_write_m),
        .mem_to_reg_m (mem_to_reg_m)
    );

    assign dm_addr = alu_result_m;    // memory stage address

    mips_writeback writeback_inst (
        .clk          (clk),
        .rst          (rst),
        .hz           (hz.writeback),
        .alu_result_m (alu_result_m),
        .dm_rdata     (dm_rdata),
        .write_reg_m  (write_reg_m),
        .reg_write_m  (reg_write_m),
        .mem_to_reg_m (mem_to_reg_m),
        .write_data_w (write_data_w),
        .write_reg_w  (write_reg_w),
        .reg_write_w  (reg_write_w)
    );

    mips_hazard_unit hazard_unit_inst (
        .hz (hz.hazard)
    );

endmodule

/* mips_pcpu_props.sv */
// ******************************
// sees the top-level ports only, a jump is legal if a beq came by on im_data
// a beq resolves 2 to 4 cycles after its fetch, with up to two stall cycles
// ******************************
`timescale 1ns/1ns
`include "mips_consts.svh"

module mips_pcpu_props
    import mips_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  dm_we,
    input word_t im_addr,
    input word_t im_data
);
    logic beq_fetch;

    assign beq_fetch = (im_data[`MIPS_OP_LSB +: 6] == `MIPS_OP_BEQ);

    // quiet memory bus and pc at zero through reset
    assert property (@(posedge clk) rst |=> (!dm_we && im_addr == `MIPS_RESET_PC))
        else $error("dm_we high or im_addr not zero during or after reset");

    assert property (@(posedge clk) disable iff (rst) !$isunknown(dm_we))
        else $error("dm_we is unknown");

    // ******************************
    // pc sequence
    // ******************************
    assert property (@(posedge clk) disable iff (rst)
        (!$past(rst) && im_addr != $past(im_addr) && im_addr != $past(im_addr) + 32'd1)
        |-> ($past(beq_fetch, 2) || $past(beq_fetch, 3) || $past(beq_fetch, 4)))
        else $error("im_addr jumped with no beq fetched before it");

endmodule

bind mips_pcpu mips_pcpu_props props_inst (
    .clk     (clk),
    .rst     (rst),
    .dm_we   (dm_we),
    .im_addr (im_addr),
    .im_data (im_data)
);

/* mips_pkg.sv */
// ******************************
// datapath is fixed at 32 bits
// ******************************
package mips_pkg;

    typedef logic [31:0] word_t;      // data word, pc or instruction
    typedef logic [4:0]  reg_num_t;
    typedef logic [15:0] imm_t;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // source of an execute operand
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,    // register file value
        FWD_MEM  = 2'b01,    // alu result in the memory stage
        FWD_WB   = 2'b10     // writeback data
    } fwd_sel_t;

endpackage

/* mips_regfile.sv */
// ******************************
// writes on the falling edge, so a read later in the cycle sees it
// ******************************
`timescale 1ns/1ns

module mips_regfile
    import mips_pkg::*;
(
    input  logic     clk,
    input  reg_num_t a_debug,
    input  reg_num_t a_rs,
    input  reg_num_t a_rt,
    output word_t    rd_debug,
    output word_t    rd_rs,
    output word_t    rd_rt,
    input  reg_num_t wa,
    input  word_t    wd,
    input  logic     we
);
    word_t regs [32];

    always_ff @(negedge clk) begin
        if (we) begin
            regs[wa] <= wd;
        end
    end

    // $0 is hardwired to zero
    assign rd_rs    = (a_rs == '0)    ? '0 : regs[a_rs];
    assign rd_rt    = (a_rt == '0)    ? '0 : regs[a_rt];
    assign rd_debug = (a_debug == '0) ? '0 : regs[a_debug];

endmodule

/* mips_writeback.sv */
// ******************************
// load data is sampled at the end of the memory cycle
// ******************************
`timescale 1ns/1ns

module mips_writeback
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    mips_hazard_if.writeback hz,
    input  word_t    alu_result_m,
    input  word_t    dm_rdata,
    input  reg_num_t write_reg_m,
    input  logic     reg_write_m,
    input  logic     mem_to_reg_m,
    output word_t    write_data_w,
    output reg_num_t write_reg_w,
    output logic     reg_write_w
);
    word_t alu_result_w, read_data_w;
    logic  mem_to_reg_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_w <= alu_result_m;
        read_data_w  <= dm_rdata;
        write_reg_w  <= write_reg_m;
    end

    assign write_data_w = mem_to_reg_w ? read_data_w : alu_result_w;

    assign hz.write_reg_w = write_reg_w;
    assign hz.reg_write_w = reg_write_w;

endmodule

/* tb_mips_pcpu.sv */
// ******************************
// memories are modelled here, 32 words each, word addressed, no wait states
// the program ends in a beq to itself, so the pc toggles between it and the next word
// ******************************
`timescale 1ns/1ns
`include "mips_consts.svh"

module tb_mips_pcpu
    import mips_pkg::*;
();
    localparam int    PERIOD          = 10;
    localparam int    RST_CYCLES      = 16;
    localparam int    PROG_LEN        = 22;
    localparam int    REG_N           = 14;
    localparam int    STORE_N         = 3;
    localparam int    DRAIN_CYCLES    = 8;     // writeback at n+4 plus stall slack
    localparam int    WATCHDOG_CYCLES = 4 * PROG_LEN + REG_N + STORE_N + 40;
    localparam word_t LOOP_PC         = 32'd21;

    logic     clk;
    logic     rst;
    reg_num_t reg_addr;
    word_t    reg_data, im_addr, im_data, dm_addr, dm_wdata, dm_rdata;
    logic     dm_we;

    word_t    imem [32];
    word_t    dmem [32];
    string    reg_name [REG_N];
    reg_num_t reg_num  [REG_N];
    word_t    reg_val  [REG_N];
    word_t    st_addr  [STORE_N];
    word_t    st_data  [STORE_N];
    int       store_count = 0;

    mips_pcpu mips_pcpu_inst (
        .clk      (clk),
        .rst      (rst),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ******************************
    // memory models
    // ******************************
    assign im_data  = imem[im_addr[4:0]];
    assign dm_rdata = dmem[dm_addr[4:0]];

    always @(posedge clk) begin
        if (dm_we === 1'b1) begin
            dmem[dm_addr[4:0]] <= dm_wdata;
        end
    end

    function automatic word_t rtype_word(logic [5:0] fn, reg_num_t rs, reg_num_t rt,
                                         reg_num_t rd);
        return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, reg_num_t rs, reg_num_t rt,
                                         imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t fill_word(int addr);
        return 32'h1234_0000 + word_t'(addr) * 32'h0000_0101;
    endfunction

    task automatic load_program();
        foreach (imem[i]) begin
            imem[i] = `MIPS_NOP;
        end
        imem[0]  = itype_word(`MIPS_OP_ADDIU, 5'd0, 5'd1, 16'd5);
        imem[1]  = itype_word(`MIPS_OP_ADDIU, 5'd0, 5'd2, imm_t'(-3));
        imem[2]  = rtype_word(`MIPS_FN_ADDU, 5'd1, 5'd2, 5'd3);     // wb and mem forward
        imem[3]  = rtype_word(`MIPS_FN_SUBU, 5'd2, 5'd1, 5'd4);     // negative minuend
        imem[4]  = rtype_word(`MIPS_FN_SLT, 5'd2, 5'd1, 5'd5);
        imem[5]  = rtype_word(`MIPS_FN_SLT, 5'd1, 5'd2, 5'd6);
        imem[6]  = rtype_word(`MIPS_FN_AND, 5'd2, 5'd1, 5'd7);
        imem[7]  = rtype_word(`MIPS_FN_OR, 5'd2, 5'd3, 5'd8);
        imem[8]  = itype_word(`MIPS_OP_LW, 5'd1, 5'd9, 16'd2);
        imem[9]  = rtype_word(`MIPS_FN_ADDU, 5'd9, 5'd1, 5'd10);    // load use
        imem[10] = itype_word(`MIPS_OP_SW, 5'd3, 5'd10, 16'd0);
        imem[11] = itype_word(`MIPS_OP_ADDIU, 5'd0, 5'd0, 16'd7);    // write to $0
        imem[12] = rtype_word(`MIPS_FN_ADDU, 5'd0, 5'd1, 5'd11);
        imem[13] = itype_word(`MIPS_OP_ADDIU, 5'd0, 5'd12, 16'd9);
        imem[14] = itype_word(`MIPS_OP_BEQ, 5'd12, 5'd1, 16'd1);     // not taken
        imem[15] = itype_word(`MIPS_OP_ADDIU, 5'd0, 5'd13, 16'd1);
        imem[16] = itype_word(`MIPS_OP_BEQ, 5'd13, 5'd13, 16'd1);    // taken
        imem[17] = itype_word(`MIPS_OP_ADDIU, 5'd0, 5'd13, 16'd99);  // skipped
        imem[18] = itype_word(`MIPS_OP_SW, 5'd12, 5'd13, 16'd3);
        imem[19] = itype_word(`MIPS_OP_LW, 5'd3, 5'd14, 16'd0);
        imem[20] = itype_word(`MIPS_OP_SW, 5'd1, 5'd14, 16'd1);
        imem[21] = itype_word(`MIPS_OP_BEQ, 5'd0, 5'd0, imm_t'(-1)); // final loop
    endtask

    task automatic fill_data_memory();
        foreach (dmem[i]) begin
            dmem[i] <= fill_word(i);
        end
    endtask

    task automatic expect_reg(int i, string name, reg_num_t num, word_t val);
        reg_name[i] = name;
        reg_num[i]  = num;
        reg_val[i]  = val;
    endtask

    task automatic expect_store(int i, word_t addr, word_t data);
        st_addr[i] = addr;
        st_data[i] = data;
    endtask

    // ******************************
    // expected results
    // ******************************
    task automatic set_expectations();
        expect_reg(0, "addiu", 5'd1, 32'd5);
        expect_reg(1, "addiu negative imm", 5'd2, 32'hffff_fffd);
        expect_reg(2, "addu forwarded", 5'd3, 32'd2);
        expect_reg(3, "subu negative", 5'd4, 32'hffff_fff8);
        expect_reg(4, "slt negative less", 5'd5, 32'd1);
        expect_reg(5, "slt positive not less", 5'd6, 32'd0);
        expect_reg(6, "and", 5'd7, 32'd5);
        expect_reg(7, "or", 5'd8, 32'hffff_ffff);
        expect_reg(8, "lw", 5'd9, fill_word(7));
        expect_reg(9, "load use addu", 5'd10, fill_word(7) + 32'd5);
        expect_reg(10, "read of $0 after write", 5'd11, 32'd5);
        expect_reg(11, "addiu before beq", 5'd12, 32'd9);
        expect_reg(12, "skipped by taken beq", 5'd13, 32'd1);
        expect_reg(13, "lw after sw", 5'd14, fill_word(7) + 32'd5);
        expect_store(0, 32'd2, fill_word(7) + 32'd5);
        expect_store(1, 32'd12, 32'd1);
        expect_store(2, 32'd6, fill_word(7) + 32'd5);
    endtask

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_reg(string name, reg_num_t num, word_t exp_val, word_t act_val);
        if (act_val !== exp_val) begin
            $display("ERR %s: reg %0d expected %h, actual %h", name, num, exp_val, act_val);
            abort_run();
        end
    endtask

    task automatic check_store(string name, word_t exp_addr, word_t act_addr,
                               word_t exp_data, word_t act_data);
        if (act_addr !== exp_addr) begin
            $display("ERR %s address: expected %h, actual %h", name, exp_addr, act_addr);
            abort_run();
        end
        if (act_data !== exp_data) begin
            $display("ERR %s data: expected %h, actual %h", name, exp_data, act_data);
            abort_run();
        end
    endtask

    // store bus is stable at the falling edge
    always @(negedge clk) begin
        if (!rst && dm_we === 1'b1) begin
            if (store_count >= STORE_N) begin
                $display("extra store to address %h with data %h", dm_addr, dm_wdata);
                abort_run();
            end else begin
                check_store($sformatf("store %0d", store_count), st_addr[store_count],
                            dm_addr, st_data[store_count], dm_wdata);
                store_count = store_count + 1;
            end
        end
    end

    initial begin
        #((RST_CYCLES + WATCHDOG_CYCLES) * PERIOD);
        $display("timeout: no result after %0d cycles", RST_CYCLES + WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        reg_addr = '0;
        load_program();
        fill_data_memory();
        set_expectations();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        while (im_addr !== LOOP_PC) begin    // final loop fetched
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (store_count != STORE_N) begin
            $display("missing store: saw %0d of %0d stores", store_count, STORE_N);
            abort_run();
        end

        for (int i = 0; i < REG_N; i++) begin
            @(posedge clk);
            reg_addr <= reg_num[i];
            @(negedge clk);
            check_reg(reg_name[i], reg_num[i], reg_val[i], reg_data);
        end

        // pc alternates between the loop and the squashed word after it
        @(posedge clk);
        reg_addr <= '0;
        @(negedge clk);
        if (im_addr != LOOP_PC) begin
            @(negedge clk);
        end
        check_reg("final pc", '0, LOOP_PC, reg_data);

        $display("Simulation PASSED");
        $finish;
    end

endmodule
